// File: Bender.yml
package:
  name: executePipe

sources:
  - source/cpuPkg.sv
  - source/aluCore.sv
  - source/aluControl.sv
  - source/branchResolve.sv
  - source/forwardUnit.sv
  - source/executeStage.sv
  - source/executeTop.sv
  - target: test
    files:
      - verif/tbClock.sv
      - verif/executeTb.sv

// File: executePipe.f
source/cpuPkg.sv
source/aluCore.sv
source/aluControl.sv
source/branchResolve.sv
source/forwardUnit.sv
source/executeStage.sv
source/executeTop.sv
verif/tbClock.sv
verif/executeTb.sv

// File: source/aluControl.sv
`timescale 1ns/100ps

module aluControl import cpuPkg::*; (
    input  execOpT    execOp,
    input  logic      bSrcImm,
    output aluFuncT   func,
    output logic      useImm,
    output resultSelT resultSel,
    output logic      linkWrite,
    output logic      err
);

    always_comb begin
        func      = FN_ADD;
        useImm    = 1'b0;
        resultSel = RES_ALU;
        linkWrite = 1'b0;
        err       = 1'b0;
        case (execOp)
            OP_NOP:     func = FN_ADD;
            OP_ADD:     func = FN_ADD;
            OP_SUB:     func = FN_SUB;
            OP_XOR:     func = FN_XOR;
            OP_ANDN:    func = FN_ANDN;
            // shifts take either rs2 or the immediate
            OP_ROL: begin
                func   = FN_ROL;
                useImm = bSrcImm;
            end
            OP_SLL: begin
                func   = FN_SLL;
                useImm = bSrcImm;
            end
            OP_ROR: begin
                func   = FN_ROR;
                useImm = bSrcImm;
            end
            OP_SRL: begin
                func   = FN_SRL;
                useImm = bSrcImm;
            end
            OP_ADDI, OP_MEMADDR: begin
                func   = FN_ADD;
                useImm = 1'b1;
            end
            OP_SUBI: begin
                func   = FN_SUB;
                useImm = 1'b1;
            end
            OP_SEQ, OP_SLT, OP_SLE: begin
                func      = FN_SUB;
                resultSel = RES_SETFLAG;
            end
            // carry out of rs1 + rs2
            OP_SCO:     resultSel = RES_SETFLAG;
            OP_BTR:     resultSel = RES_BTR;
            OP_LBI:     resultSel = RES_IMM;
            OP_SLBI:    resultSel = RES_SLBI;
            // flags of rs1 - 0
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: func = FN_SUB;
            OP_J, OP_JR: func = FN_ADD;
            OP_JAL, OP_JALR: begin
                resultSel = RES_LINK;
                linkWrite = 1'b1;
            end
            default:    err = 1'b1;
        endcase
    end

endmodule

// File: source/aluCore.sv
`timescale 1ns/100ps

module aluCore import cpuPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  aluFuncT              func,
    output logic [dataWidth-1:0] result,
    output logic                 carry,
    output logic                 overflow,
    output logic                 zero,
    output logic                 negative
);

    logic                     subtract;
    logic [dataWidth-1:0]     bEff;
    logic [dataWidth:0]       sum;
    logic [3:0]               shAmt;
    logic [2*dataWidth-1:0]   rolWide;
    logic [2*dataWidth-1:0]   rorWide;

    // a - b done as a + ~b + 1
    assign subtract = (func == FN_SUB);
    assign bEff     = subtract ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, bEff} + {{dataWidth{1'b0}}, subtract};

    assign carry    = sum[dataWidth];
    // signs of inputs agree but sum sign differs
    assign overflow = (a[dataWidth-1] == bEff[dataWidth-1]) &&
                      (sum[dataWidth-1] != a[dataWidth-1]);

    assign shAmt = b[3:0];

    // rotates through a doubled copy of a
    assign rolWide = {a, a} << shAmt;
    assign rorWide = {a, a} >> shAmt;

    always_comb begin
        case (func)
            FN_ADD: begin
                result = sum[dataWidth-1:0];
            end
            FN_SUB: begin
                result = sum[dataWidth-1:0];
            end
            FN_XOR: begin
                result = a ^ b;
            end
            FN_ANDN: begin
                result = a & ~b;
            end
            FN_ROL: begin
                result = rolWide[2*dataWidth-1:dataWidth];
            end
            FN_SLL: begin
                result = a << shAmt;
            end
            FN_ROR: begin
                result = rorWide[dataWidth-1:0];
            end
            FN_SRL: begin
                result = a >> shAmt;
            end
            default: begin
                result = sum[dataWidth-1:0];
            end
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[dataWidth-1];

endmodule

// File: source/branchResolve.sv
`timescale 1ns/100ps

module branchResolve import cpuPkg::*; (
    input  execOpT               execOp,
    input  logic                 zero,
    input  logic                 negative,
    input  logic [dataWidth-1:0] rs1Val,
    input  logic [dataWidth-1:0] imm,
    input  logic [dataWidth-1:0] pcPlus2,
    output logic                 takeBranch,
    output logic [dataWidth-1:0] nextPc
);

    logic [dataWidth-1:0] relTarget;
    logic [dataWidth-1:0] regTarget;
    logic                 useReg;

    assign relTarget = pcPlus2 + imm;
    assign regTarget = rs1Val + imm;

    always_comb begin
        useReg = 1'b0;
        case (execOp)
            OP_BEQZ:       takeBranch = zero;
            OP_BNEZ:       takeBranch = ~zero;
            OP_BLTZ:       takeBranch = negative;
            OP_BGEZ:       takeBranch = ~negative;
            OP_J, OP_JAL:  takeBranch = 1'b1;
            OP_JR, OP_JALR: begin
                takeBranch = 1'b1;
                useReg     = 1'b1;
            end
            default:       takeBranch = 1'b0;
        endcase
    end

    assign nextPc = !takeBranch ? pcPlus2 : (useReg ? regTarget : relTarget);

endmodule

// File: source/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth    = 16;
    localparam int regAddrWidth = 3;

    // JAL and JALR always write the link register
    localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

    // execute opcodes, 5'h1b..5'h1f reserved
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_ADD     = 5'h01,
        OP_SUB     = 5'h02,
        OP_XOR     = 5'h03,
        OP_ANDN    = 5'h04,
        OP_ROL     = 5'h05,
        OP_SLL     = 5'h06,
        OP_ROR     = 5'h07,
        OP_SRL     = 5'h08,
        OP_ADDI    = 5'h09,
        OP_SUBI    = 5'h0a,
        OP_SEQ     = 5'h0b,
        OP_SLT     = 5'h0c,
        OP_SLE     = 5'h0d,
        OP_SCO     = 5'h0e,
        OP_BTR     = 5'h0f,
        OP_LBI     = 5'h10,
        OP_SLBI    = 5'h11,
        OP_MEMADDR = 5'h12,
        OP_BEQZ    = 5'h13,
        OP_BNEZ    = 5'h14,
        OP_BLTZ    = 5'h15,
        OP_BGEZ    = 5'h16,
        OP_J       = 5'h17,
        OP_JAL     = 5'h18,
        OP_JR      = 5'h19,
        OP_JALR    = 5'h1a
    } execOpT;

    typedef enum logic [2:0] {
        FN_ADD  = 3'd0,
        FN_SUB  = 3'd1,
        FN_XOR  = 3'd2,
        FN_ANDN = 3'd3,
        FN_ROL  = 3'd4,
        FN_SLL  = 3'd5,
        FN_ROR  = 3'd6,
        FN_SRL  = 3'd7
    } aluFuncT;

    typedef enum logic [2:0] {
        RES_ALU     = 3'd0,
        RES_SETFLAG = 3'd1,
        RES_BTR     = 3'd2,
        RES_IMM     = 3'd3,
        RES_SLBI    = 3'd4,
        RES_LINK    = 3'd5
    } resultSelT;

    typedef enum logic [1:0] {
        FWD_REGFILE   = 2'd0,
        FWD_WRITEBACK = 2'd1,
        FWD_EXMEM     = 2'd2
    } fwdSelT;

endpackage

// File: source/executeStage.sv
`timescale 1ns/100ps

module executeStage import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  fwdSelT                  fwdA,
    input  fwdSelT                  fwdB,
    input  execOpT                  execOp,
    input  logic                    bSrcImm,
    input  logic [dataWidth-1:0]    rs1Val,
    input  logic [dataWidth-1:0]    rs2Val,
    input  logic [dataWidth-1:0]    imm,
    input  logic [dataWidth-1:0]    pc,
    input  logic [dataWidth-1:0]    pcPlus2,
    input  logic [regAddrWidth-1:0] wrReg,
    input  logic                    regWrite,
    input  logic                    memToReg,
    input  logic                    memWrite,
    input  logic                    memRead,
    input  logic                    halt,
    input  logic [dataWidth-1:0]    wbData,
    output logic [dataWidth-1:0]    resultMem,
    output logic [dataWidth-1:0]    storeDataMem,
    output logic [dataWidth-1:0]    nextPcMem,
    output logic [regAddrWidth-1:0] wrRegMem,
    output logic                    regWriteMem,
    output logic                    memToRegMem,
    output logic                    memWriteMem,
    output logic                    memReadMem,
    output logic                    haltMem,
    output logic                    takeBranchMem,
    output logic                    takeBranch,
    output logic                    err
);

    logic [dataWidth-1:0]    opA, opB, rs2Fwd, aluResult, result, nextPc, rs1Rev;
    logic [dataWidth-1:0]    nextPcIn;
    logic [regAddrWidth-1:0] wrRegIn;
    logic                    carry, overflow, zero, negative;
    logic                    useImm, linkWrite, isBranch, lessThan, flagBit;
    logic                    regWriteIn, memWriteIn, memReadIn, haltIn;
    aluFuncT                 func;
    resultSelT               resultSel;

    function automatic logic [dataWidth-1:0] fwdMux(
        input fwdSelT               sel,
        input logic [dataWidth-1:0] regVal,
        input logic [dataWidth-1:0] exMemVal,
        input logic [dataWidth-1:0] wbVal
    );
        case (sel)
            FWD_EXMEM:     return exMemVal;
            FWD_WRITEBACK: return wbVal;
            default:       return regVal;
        endcase
    endfunction

    assign opA    = fwdMux(fwdA, rs1Val, resultMem, wbData);
    assign rs2Fwd = fwdMux(fwdB, rs2Val, resultMem, wbData);

    // conditional branches compare rs1 against zero
    assign isBranch = execOp inside {OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ};
    assign opB      = isBranch ? '0 : (useImm ? imm : rs2Fwd);

    aluControl ctrl0 (.execOp, .bSrcImm, .func, .useImm, .resultSel, .linkWrite, .err);

    aluCore alu0 (.a(opA), .b(opB), .func, .result(aluResult), .carry, .overflow,
        .zero, .negative);

    branchResolve br0 (.execOp, .zero, .negative, .rs1Val(opA), .imm, .pcPlus2,
        .takeBranch, .nextPc);

    // sign of rs1 - rs2 corrected for overflow
    assign lessThan = negative ^ overflow;

    always_comb begin
        case (execOp)
            OP_SEQ:  flagBit = zero;
            OP_SLT:  flagBit = lessThan;
            OP_SLE:  flagBit = lessThan | zero;
            OP_SCO:  flagBit = carry;
            default: flagBit = 1'b0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < dataWidth; i++) begin
            rs1Rev[i] = opA[dataWidth-1-i];
        end
    end

    always_comb begin
        case (resultSel)
            RES_SETFLAG: result = {{(dataWidth-1){1'b0}}, flagBit};
            RES_BTR:     result = rs1Rev;
            RES_IMM:     result = imm;
            RES_SLBI:    result = (opA << 8) | imm;
            RES_LINK:    result = pcPlus2;
            default:     result = aluResult;
        endcase
    end

    // squash the instruction behind a taken branch
    assign regWriteIn = regWrite & ~takeBranchMem;
    assign memWriteIn = memWrite & ~takeBranchMem;
    assign memReadIn  = memRead & ~takeBranchMem;
    assign haltIn     = halt & ~takeBranchMem;

    assign wrRegIn  = linkWrite ? linkReg : wrReg;
    // a halted machine keeps pointing at the halt
    assign nextPcIn = haltIn ? pc : nextPc;

    always_ff @(posedge clk) begin
        if (rst) begin
            resultMem     <= '0;
            storeDataMem  <= '0;
            nextPcMem     <= '0;
            wrRegMem      <= '0;
            regWriteMem   <= 1'b0;
            memToRegMem   <= 1'b0;
            memWriteMem   <= 1'b0;
            memReadMem    <= 1'b0;
            haltMem       <= 1'b0;
            takeBranchMem <= 1'b0;
        end else if (advance) begin
            resultMem     <= result;
            storeDataMem  <= rs2Fwd;
            nextPcMem     <= nextPcIn;
            wrRegMem      <= wrRegIn;
            regWriteMem   <= regWriteIn;
            memToRegMem   <= memToReg;
            memWriteMem   <= memWriteIn;
            memReadMem    <= memReadIn;
            haltMem       <= haltIn;
            takeBranchMem <= takeBranch;
        end
    end

endmodule

// File: source/executeTop.sv
`timescale 1ns/100ps

module executeTop import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  execOpT                  execOp,
    input  logic                    bSrcImm,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic [dataWidth-1:0]    rs1Val,
    input  logic [dataWidth-1:0]    rs2Val,
    input  logic [dataWidth-1:0]    imm,
    input  logic [dataWidth-1:0]    pc,
    input  logic [dataWidth-1:0]    pcPlus2,
    input  logic [regAddrWidth-1:0] wrReg,
    input  logic                    regWrite,
    input  logic                    memToReg,
    input  logic                    memWrite,
    input  logic                    memRead,
    input  logic                    halt,
    input  logic [regAddrWidth-1:0] wbReg,
    input  logic                    wbRegWrite,
    input  logic [dataWidth-1:0]    wbData,
    output logic                    takeBranch,
    output logic [dataWidth-1:0]    resultMem,
    output logic [dataWidth-1:0]    storeDataMem,
    output logic [dataWidth-1:0]    nextPcMem,
    output logic [regAddrWidth-1:0] wrRegMem,
    output logic                    regWriteMem,
    output logic                    memToRegMem,
    output logic                    memWriteMem,
    output logic                    memReadMem,
    output logic                    haltMem,
    output logic                    takeBranchMem,
    output logic                    err
);

    fwdSelT fwdA;
    fwdSelT fwdB;

    forwardUnit fwd0 (.rs1, .rs2, .wrRegMem, .wbReg, .regWriteMem, .wbRegWrite,
        .fwdA, .fwdB);

    executeStage exec0 (.clk, .rst, .advance, .fwdA, .fwdB, .execOp, .bSrcImm,
        .rs1Val, .rs2Val, .imm, .pc, .pcPlus2, .wrReg, .regWrite, .memToReg,
        .memWrite, .memRead, .halt, .wbData, .resultMem, .storeDataMem, .nextPcMem,
        .wrRegMem, .regWriteMem, .memToRegMem, .memWriteMem, .memReadMem, .haltMem,
        .takeBranchMem, .takeBranch, .err);

endmodule

// File: source/forwardUnit.sv
`timescale 1ns/100ps

module forwardUnit import cpuPkg::*; (
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic [regAddrWidth-1:0] wrRegMem,
    input  logic [regAddrWidth-1:0] wbReg,
    input  logic                    regWriteMem,
    input  logic                    wbRegWrite,
    output fwdSelT                  fwdA,
    output fwdSelT                  fwdB
);

    // r0 is a normal register, so no zero check here
    always_comb begin
        if (regWriteMem && (wrRegMem == rs1)) begin
            fwdA = FWD_EXMEM;
        end else if (wbRegWrite && (wbReg == rs1)) begin
            fwdA = FWD_WRITEBACK;
        end else begin
            fwdA = FWD_REGFILE;
        end
    end

    always_comb begin
        if (regWriteMem && (wrRegMem == rs2)) begin
            fwdB = FWD_EXMEM;
        end else if (wbRegWrite && (wbReg == rs2)) begin
            fwdB = FWD_WRITEBACK;
        end else begin
            fwdB = FWD_REGFILE;
        end
    end

endmodule

// File: verif/execInput.mem
// grp op bImm rs1 rs2 rs1Val rs2Val imm pcPlus2 ctl{wrReg,halt,rd,wr,toReg,regWr} wb{wr,reg}
// wbData advance, expected: result store nextPc takeBranch ctl{takeBranchMem,wrReg,..} err
1 01 0 0 1 7fff 0001 0000 0102 61 0 0000 1  8000 0001 0102 0 061 0
1 02 0 0 1 0000 0001 0000 0104 61 0 0000 1  ffff 0001 0104 0 061 0
1 03 0 0 1 a5a5 0ff0 0000 0106 61 0 0000 1  aa55 0ff0 0106 0 061 0
1 04 0 0 1 a5a5 0ff0 0000 0108 61 0 0000 1  a005 0ff0 0108 0 061 0
1 09 1 0 1 7ffe 1234 0003 010a 61 0 0000 1  8001 1234 010a 0 061 0
1 0a 1 0 1 0005 0000 0007 010c 61 0 0000 1  fffe 0000 010c 0 061 0
1 05 0 0 1 8001 0004 0000 010e 61 0 0000 1  0018 0004 010e 0 061 0
1 05 1 0 1 1234 0003 0008 0110 61 0 0000 1  3412 0003 0110 0 061 0
1 06 1 0 1 8001 0000 000f 0112 61 0 0000 1  8000 0000 0112 0 061 0
1 07 0 0 1 0001 0001 0000 0114 61 0 0000 1  8000 0001 0114 0 061 0
1 08 1 0 1 f0f0 0000 0014 0116 61 0 0000 1  0f0f 0000 0116 0 061 0
2 0b 0 0 1 0005 0005 0000 0120 61 0 0000 1  0001 0005 0120 0 061 0
2 0c 0 0 1 8000 0001 0000 0122 61 0 0000 1  0001 0001 0122 0 061 0
2 0c 0 0 1 7fff 8000 0000 0124 61 0 0000 1  0000 8000 0124 0 061 0
2 0d 0 0 1 0003 0003 0000 0126 61 0 0000 1  0001 0003 0126 0 061 0
2 0e 0 0 1 ffff 0001 0000 0128 61 0 0000 1  0001 0001 0128 0 061 0
2 0f 0 0 1 1234 0000 0000 012a 61 0 0000 1  2c48 0000 012a 0 061 0
2 10 0 0 1 0000 0000 ff80 012c 61 0 0000 1  ff80 0000 012c 0 061 0
2 11 0 0 1 00ab 0000 00cd 012e 61 0 0000 1  abcd 0000 012e 0 061 0
2 12 0 0 3 1000 5555 0010 0130 64 0 0000 1  1010 abcd 0130 0 064 0
2 12 0 0 1 2000 0000 fffe 0132 6b 0 0000 1  1ffe 0000 0132 0 06b 0
3 13 0 0 1 0000 0000 0010 0200 00 0 0000 1  0000 0000 0210 1 100 0
3 13 0 0 1 0001 0000 0010 0202 00 0 0000 1  0001 0000 0202 0 000 0
3 14 0 0 1 0001 0000 0010 0204 00 0 0000 1  0001 0000 0214 1 100 0
3 14 0 0 1 0000 0000 0010 0206 00 0 0000 1  0000 0000 0206 0 000 0
3 15 0 0 1 8000 0000 0010 0208 00 0 0000 1  8000 0000 0218 1 100 0
3 15 0 0 1 7fff 0000 0010 020a 00 0 0000 1  7fff 0000 020a 0 000 0
3 18 0 0 1 0000 0000 0040 0210 01 0 0000 1  0210 0000 0250 1 1e1 0
3 16 0 0 1 0000 0000 0010 020c 00 0 0000 1  0000 0000 021c 1 100 0
3 16 0 0 1 ffff 0000 0010 020e 00 0 0000 1  ffff 0000 020e 0 000 0
3 1a 0 0 1 4000 0000 0004 0220 01 0 0000 1  0220 0000 4004 1 1e1 0
3 17 0 0 1 0000 0000 fff0 0300 00 0 0000 1  0000 0000 02f0 1 100 0
3 19 0 0 1 1000 0000 0020 0302 00 0 0000 1  1000 0000 1020 1 100 0
5 01 0 0 1 0003 0004 0000 0310 7f 0 0000 1  0007 0004 0310 0 062 0
5 01 0 0 1 0100 0200 0000 0312 41 0 0000 0  0007 0004 0310 0 062 0
5 13 0 0 1 0000 0000 0010 0314 00 0 0000 0  0007 0004 0310 1 062 0
5 1b 0 0 1 0000 0000 0000 0316 00 0 0000 1  0000 0000 0316 0 000 1
4 01 0 0 1 0010 0020 0000 0320 41 0 0000 1  0030 0020 0320 0 041 0
4 02 0 2 1 9999 0005 0000 0322 61 0 0000 1  002b 0005 0322 0 061 0
4 01 0 4 1 1111 0001 0000 0324 a1 c 0100 1  0101 0001 0324 0 0a1 0
4 01 0 5 1 2222 0002 0000 0326 c0 d 7777 1  0103 0002 0326 0 0c0 0

// File: verif/executeTb.sv
`timescale 1ns/100ps

module executeTb import cpuPkg::*; ();

    logic                    clk, rst, advance, bSrcImm;
    execOpT                  execOp;
    logic [regAddrWidth-1:0] rs1, rs2, wrReg, wbReg;
    logic [dataWidth-1:0]    rs1Val, rs2Val, imm, pc, pcPlus2, wbData;
    logic                    regWrite, memToReg, memWrite, memRead, halt, wbRegWrite;
    logic                    takeBranch, err;
    logic [dataWidth-1:0]    resultMem, storeDataMem, nextPcMem;
    logic [regAddrWidth-1:0] wrRegMem;
    logic                    regWriteMem, memToRegMem, memWriteMem, memReadMem, haltMem;
    logic                    takeBranchMem;
    logic [15:0]             ctlMem;
    logic [15:0]             vecMem [0:1023];
    logic                    loaded = 1'b0;
    integer                  seed;
    int                      vecWords = 19;
    int                      fillerCount = 8;
    int                      numVec, vecIdx, curGroup;
    int                      passCount, failCount, groupChecks, groupFails;
    string                   groupName [0:6];

    tbClock clkGen (.clk, .rst);

    executeTop dut0 (.*);

    // packed like the expected control column of the vector file
    assign ctlMem = {7'd0, takeBranchMem, wrRegMem, haltMem, memReadMem, memWriteMem,
        memToRegMem, regWriteMem};

    task automatic checkValue(input string name, input logic [15:0] got,
            input logic [15:0] expected);
        groupChecks++;
        assert (got === expected) begin
            passCount++;
        end else begin
            $display("FAILED at %0t ns: vector %0d, %s is %h, expected %h",
                $time, vecIdx, name, got, expected);
            failCount++;
            groupFails++;
        end
    endtask

    task automatic finishGroup();
        if (groupChecks > 0) begin
            $display("group %0d (%s) finished: %0d checks, %0d failed",
                curGroup, groupName[curGroup], groupChecks, groupFails);
        end
        groupChecks = 0;
        groupFails  = 0;
    endtask

    task automatic driveIdle();
        {advance, bSrcImm, regWrite, memToReg, memWrite, memRead, halt} = '0;
        execOp = OP_NOP;
        {rs1, rs2, wrReg, wbReg, wbRegWrite} = '0;
        {rs1Val, rs2Val, imm, pc, pcPlus2, wbData} = '0;
    endtask

    task automatic driveVector(input int base);
        execOp  = execOpT'(vecMem[base+1][4:0]);
        bSrcImm = vecMem[base+2][0];
        rs1     = vecMem[base+3][2:0];
        rs2     = vecMem[base+4][2:0];
        rs1Val  = vecMem[base+5];
        rs2Val  = vecMem[base+6];
        imm     = vecMem[base+7];
        pcPlus2 = vecMem[base+8];
        pc      = vecMem[base+8] - 16'd2;
        {wrReg, halt, memRead, memWrite, memToReg, regWrite} = vecMem[base+9][7:0];
        {wbRegWrite, wbReg} = vecMem[base+10][3:0];
        wbData  = vecMem[base+11];
        advance = vecMem[base+12][0];
    endtask

    // random NOPs that keep regWrite and wbRegWrite low
    task automatic runFiller();
        for (int i = 0; i < fillerCount; i++) begin
            driveIdle();
            vecIdx  = numVec + i;
            rs1     = $random(seed);
            rs2     = $random(seed);
            rs1Val  = $random(seed);
            rs2Val  = $random(seed);
            imm     = $random(seed);
            pcPlus2 = $random(seed) & 16'hfffe;
            pc      = pcPlus2 - 16'd2;
            wrReg   = $random(seed);
            {halt, memRead, memWrite, memToReg} = $random(seed);
            advance = 1'b1;
            #10;
            checkValue("takeBranch", takeBranch, 16'd0);
            checkValue("err", err, 16'd0);
            @(negedge clk);
            checkValue("storeDataMem", storeDataMem, rs2Val);
            if (!halt) begin
                checkValue("nextPcMem", nextPcMem, pcPlus2);
            end
            checkValue("control", ctlMem,
                {8'd0, wrReg, halt, memRead, memWrite, memToReg, 1'b0});
        end
    endtask

    initial begin
        int base;
        seed = 13;
        {passCount, failCount, groupChecks, groupFails} = '0;
        groupName = '{"reset", "arithmetic and logic", "special results",
            "branches and jumps", "forwarding", "flush, stall and err", "random NOP filler"};
        driveIdle();
        for (int i = 0; i < 1024; i++) begin
            vecMem[i] = 16'hffff;
        end
        $readmemh("verif/execInput.mem", vecMem);
        numVec = 0;
        while ((numVec + 1) * vecWords <= 1024 && vecMem[numVec * vecWords] != 16'hffff) begin
            numVec++;
        end
        if (numVec == 0) begin
            $display("no test vectors could be read from verif/execInput.mem");
            failCount++;
        end
        loaded = 1'b1;

        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        curGroup = 0;
        vecIdx   = -1;
        checkValue("resultMem", resultMem, 16'd0);
        checkValue("storeDataMem", storeDataMem, 16'd0);
        checkValue("nextPcMem", nextPcMem, 16'd0);
        checkValue("control", ctlMem, 16'd0);

        for (int v = 0; v < numVec; v++) begin
            base   = v * vecWords;
            vecIdx = v;
            if (vecMem[base] != curGroup) begin
                finishGroup();
                curGroup = vecMem[base];
            end
            driveVector(base);
            // combinational outputs well before the rising edge
            #10;
            checkValue("takeBranch", takeBranch, vecMem[base+16]);
            checkValue("err", err, vecMem[base+18]);
            @(negedge clk);
            checkValue("resultMem", resultMem, vecMem[base+13]);
            checkValue("storeDataMem", storeDataMem, vecMem[base+14]);
            checkValue("nextPcMem", nextPcMem, vecMem[base+15]);
            checkValue("control", ctlMem, vecMem[base+17]);
        end
        finishGroup();
        curGroup = 6;
        runFiller();
        finishGroup();

        $display("checks passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // vectors plus filler and 20 cycles of margin for reset
    initial begin
        wait (loaded);
        #((numVec + fillerCount + 20) * 40);
        $display("the run timed out before all vectors were checked");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: verif/tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic rst
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // held over four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
